//--- Makefile
TOP := tb_atomics_adapter

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing -f sim.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

//--- amo/amo_alu.sv
`timescale 1ns/1ps

module amo_alu import atomics_pkg::*; (
    input  amo_op_e               op_i,
    input  logic [DATA_WIDTH-1:0] mem_data_i,
    input  logic [DATA_WIDTH-1:0] operand_i,
    output logic [DATA_WIDTH-1:0] result_o
);

    logic signed_less;
    logic unsigned_less;

    // Both comparisons ask whether the operand is below the memory word
    assign signed_less   = $signed(operand_i) < $signed(mem_data_i);
    assign unsigned_less = operand_i < mem_data_i;

    always_comb begin
        case (op_i)
            OP_ADD:  result_o = mem_data_i + operand_i;
            OP_AND:  result_o = mem_data_i & operand_i;
            OP_OR:   result_o = mem_data_i | operand_i;
            OP_XOR:  result_o = mem_data_i ^ operand_i;
            OP_MAX:  result_o = signed_less ? mem_data_i : operand_i;
            OP_MIN:  result_o = signed_less ? operand_i : mem_data_i;
            OP_MAXU: result_o = unsigned_less ? mem_data_i : operand_i;
            OP_MINU: result_o = unsigned_less ? operand_i : mem_data_i;
            // Swap writes the operand as it is
            default: result_o = operand_i;
        endcase
    end

endmodule

//--- amo/amo_sequencer.sv
`timescale 1ns/1ps

module amo_sequencer import atomics_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,

    input  amo_req_t  slv_req_i,
    input  logic      slv_req_valid_i,
    output logic      slv_req_ready_o,
    output amo_rsp_t  slv_rsp_o,
    output logic      slv_rsp_valid_o,
    input  logic      slv_rsp_ready_i,

    output core_req_t core_req_o,
    output logic      core_req_valid_o,
    input  logic      core_req_ready_i,
    input  amo_rsp_t  core_rsp_i,
    input  logic      core_rsp_valid_i,
    output logic      core_rsp_ready_o
);

    typedef enum logic [2:0] {
        IDLE,
        ISSUE,
        WAIT_RD,
        WRITE,
        WAIT_WR,
        RESPOND
    } state_e;

    state_e                state_q;
    state_e                state_d;
    amo_req_t              req_q;
    amo_rsp_t              rsp_q;
    logic                  is_amo;
    logic [DATA_WIDTH-1:0] alu_result;

    assign is_amo = !(req_q.op inside {OP_LOAD, OP_STORE, OP_LR, OP_SC});

    // The old word sits in rsp_q from the read response until the write is sent
    amo_alu i_amo_alu (
        .op_i       ( req_q.op    ),
        .mem_data_i ( rsp_q.rdata ),
        .operand_i  ( req_q.wdata ),
        .result_o   ( alu_result  )
    );

    assign slv_req_ready_o  = (state_q == IDLE);
    assign core_req_valid_o = (state_q == ISSUE) || (state_q == WRITE);
    assign core_rsp_ready_o = (state_q == WAIT_RD) || (state_q == WAIT_WR);
    assign slv_rsp_valid_o  = (state_q == RESPOND);
    assign slv_rsp_o        = rsp_q;

    always_comb begin
        core_req_o.addr  = req_q.addr;
        core_req_o.id    = req_q.id;
        core_req_o.wdata = req_q.wdata;
        case (req_q.op)
            OP_STORE: core_req_o.op = CORE_STORE;
            OP_LR:    core_req_o.op = CORE_LR;
            OP_SC:    core_req_o.op = CORE_SC;
            default:  core_req_o.op = CORE_LOAD;
        endcase
        // Second half of an AMO stores the computed word
        if (state_q == WRITE) begin
            core_req_o.op    = CORE_STORE;
            core_req_o.wdata = alu_result;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (slv_req_valid_i)
                    state_d = ISSUE;
            end
            ISSUE: begin
                if (core_req_ready_i)
                    state_d = WAIT_RD;
            end
            WAIT_RD: begin
                if (core_rsp_valid_i)
                    state_d = is_amo ? WRITE : RESPOND;
            end
            WRITE: begin
                if (core_req_ready_i)
                    state_d = WAIT_WR;
            end
            WAIT_WR: begin
                if (core_rsp_valid_i)
                    state_d = RESPOND;
            end
            RESPOND: begin
                if (slv_rsp_ready_i)
                    state_d = IDLE;
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i)
            state_q <= IDLE;
        else
            state_q <= state_d;
    end

    always_ff @(posedge clk_i) begin
        if (slv_req_ready_o && slv_req_valid_i)
            req_q <= slv_req_i;
        if (state_q == WAIT_RD && core_rsp_valid_i)
            rsp_q <= core_rsp_i;
        // Keep the old word as AMO result, only the id comes from the write
        if (state_q == WAIT_WR && core_rsp_valid_i)
            rsp_q.id <= core_rsp_i.id;
    end

endmodule

//--- common/atomics_pkg.sv
package atomics_pkg;

    localparam int unsigned ADDR_WIDTH = 32;
    localparam int unsigned DATA_WIDTH = 32;
    localparam int unsigned NUM_IDS    = 4;
    localparam int unsigned ID_WIDTH   = 2;

    // Requester opcodes, the RV32A word AMOs plus plain and reserved accesses
    typedef enum logic [3:0] {
        OP_LOAD,
        OP_STORE,
        OP_LR,
        OP_SC,
        OP_SWAP,
        OP_ADD,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_MAX,
        OP_MIN,
        OP_MAXU,
        OP_MINU
    } amo_op_e;

    // What remains once the AMO stage has split atomics into a read and a write
    typedef enum logic [1:0] {
        CORE_LOAD,
        CORE_STORE,
        CORE_LR,
        CORE_SC
    } core_op_e;

    typedef struct packed {
        amo_op_e               op;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] wdata;
        logic [ID_WIDTH-1:0]   id;
    } amo_req_t;

    typedef struct packed {
        core_op_e              op;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] wdata;
        logic [ID_WIDTH-1:0]   id;
    } core_req_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] rdata;
        logic [ID_WIDTH-1:0]   id;
    } amo_rsp_t;

    typedef struct packed {
        logic                  we;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] rdata;
    } mem_rsp_t;

endpackage

//--- lrsc/lrsc_filter.sv
`timescale 1ns/1ps

module lrsc_filter import atomics_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,

    input  core_req_t core_req_i,
    input  logic      core_req_valid_i,
    output logic      core_req_ready_o,
    output amo_rsp_t  core_rsp_o,
    output logic      core_rsp_valid_o,
    input  logic      core_rsp_ready_i,

    output mem_req_t  mst_req_o,
    output logic      mst_req_valid_o,
    input  logic      mst_req_ready_i,
    input  mem_rsp_t  mst_rsp_i,
    input  logic      mst_rsp_valid_i,
    output logic      mst_rsp_ready_o
);

    typedef enum logic [1:0] {
        IDLE,
        MEM_REQ,
        MEM_WAIT,
        RESPOND
    } state_e;

    state_e    state_q;
    state_e    state_d;
    core_req_t req_q;
    amo_rsp_t  rsp_q;
    logic      accept;
    logic      match;
    logic      sc_fail;
    logic      is_write;

    assign accept   = (state_q == IDLE) && core_req_valid_i;
    assign sc_fail  = (core_req_i.op == CORE_SC) && !match;
    assign is_write = (core_req_i.op == CORE_STORE) || ((core_req_i.op == CORE_SC) && match);

    // With one request in flight the table can be updated at acceptance
    reservation_table i_reservation_table (
        .clk_i     ( clk_i                                 ),
        .rst_i     ( rst_i                                 ),
        .id_i      ( core_req_i.id                         ),
        .addr_i    ( core_req_i.addr                       ),
        .reserve_i ( accept && (core_req_i.op == CORE_LR)  ),
        .release_i ( accept && (core_req_i.op == CORE_SC)  ),
        .write_i   ( accept && is_write                    ),
        .match_o   ( match                                 )
    );

    assign core_req_ready_o = (state_q == IDLE);
    assign mst_req_valid_o  = (state_q == MEM_REQ);
    assign mst_rsp_ready_o  = (state_q == MEM_WAIT);
    assign core_rsp_valid_o = (state_q == RESPOND);
    assign core_rsp_o       = rsp_q;

    // Only a successful SC ever gets this far
    assign mst_req_o.we    = (req_q.op == CORE_STORE) || (req_q.op == CORE_SC);
    assign mst_req_o.addr  = req_q.addr;
    assign mst_req_o.wdata = req_q.wdata;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (core_req_valid_i)
                    state_d = sc_fail ? RESPOND : MEM_REQ;
            end
            MEM_REQ: begin
                if (mst_req_ready_i)
                    state_d = MEM_WAIT;
            end
            MEM_WAIT: begin
                if (mst_rsp_valid_i)
                    state_d = RESPOND;
            end
            RESPOND: begin
                if (core_rsp_ready_i)
                    state_d = IDLE;
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i)
            state_q <= IDLE;
        else
            state_q <= state_d;
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_q <= core_req_i;
            if (sc_fail) begin
                rsp_q.rdata <= DATA_WIDTH'(1);
                rsp_q.id    <= core_req_i.id;
            end
        end
        if (state_q == MEM_WAIT && mst_rsp_valid_i) begin
            rsp_q.rdata <= mst_req_o.we ? '0 : mst_rsp_i.rdata;
            rsp_q.id    <= req_q.id;
        end
    end

endmodule

//--- lrsc/reservation_table.sv
`timescale 1ns/1ps

module reservation_table import atomics_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic [ID_WIDTH-1:0]   id_i,
    input  logic [ADDR_WIDTH-1:0] addr_i,
    input  logic                  reserve_i,
    input  logic                  release_i,
    input  logic                  write_i,
    output logic                  match_o
);

    logic [NUM_IDS-1:0]    valid_q;
    logic [ADDR_WIDTH-1:0] addr_q [NUM_IDS];

    assign match_o = valid_q[id_i] && (addr_q[id_i] == addr_i);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
        end else begin
            for (int i = 0; i < NUM_IDS; i++) begin
                // A write anywhere on the reserved word breaks every reservation on it
                if (write_i && addr_q[i] == addr_i)
                    valid_q[i] <= 1'b0;
                if (release_i && id_i == ID_WIDTH'(i))
                    valid_q[i] <= 1'b0;
                if (reserve_i && id_i == ID_WIDTH'(i))
                    valid_q[i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reserve_i)
            addr_q[id_i] <= addr_i;
    end

endmodule

//--- rtl/atomics_adapter.sv
`timescale 1ns/1ps

module atomics_adapter import atomics_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,

    input  amo_req_t  slv_req_i,
    input  logic      slv_req_valid_i,
    output logic      slv_req_ready_o,
    output amo_rsp_t  slv_rsp_o,
    output logic      slv_rsp_valid_o,
    input  logic      slv_rsp_ready_i,

    output mem_req_t  mst_req_o,
    output logic      mst_req_valid_o,
    input  logic      mst_req_ready_i,
    input  mem_rsp_t  mst_rsp_i,
    input  logic      mst_rsp_valid_i,
    output logic      mst_rsp_ready_o
);

    core_req_t core_req;
    logic      core_req_valid;
    logic      core_req_ready;
    amo_rsp_t  core_rsp;
    logic      core_rsp_valid;
    logic      core_rsp_ready;

    // AMOs are resolved first so that their stores pass the reservation logic
    amo_sequencer i_amo_sequencer (
        .clk_i            ( clk_i           ),
        .rst_i            ( rst_i           ),
        .slv_req_i        ( slv_req_i       ),
        .slv_req_valid_i  ( slv_req_valid_i ),
        .slv_req_ready_o  ( slv_req_ready_o ),
        .slv_rsp_o        ( slv_rsp_o       ),
        .slv_rsp_valid_o  ( slv_rsp_valid_o ),
        .slv_rsp_ready_i  ( slv_rsp_ready_i ),
        .core_req_o       ( core_req        ),
        .core_req_valid_o ( core_req_valid  ),
        .core_req_ready_i ( core_req_ready  ),
        .core_rsp_i       ( core_rsp        ),
        .core_rsp_valid_i ( core_rsp_valid  ),
        .core_rsp_ready_o ( core_rsp_ready  )
    );

    lrsc_filter i_lrsc_filter (
        .clk_i            ( clk_i           ),
        .rst_i            ( rst_i           ),
        .core_req_i       ( core_req        ),
        .core_req_valid_i ( core_req_valid  ),
        .core_req_ready_o ( core_req_ready  ),
        .core_rsp_o       ( core_rsp        ),
        .core_rsp_valid_o ( core_rsp_valid  ),
        .core_rsp_ready_i ( core_rsp_ready  ),
        .mst_req_o        ( mst_req_o       ),
        .mst_req_valid_o  ( mst_req_valid_o ),
        .mst_req_ready_i  ( mst_req_ready_i ),
        .mst_rsp_i        ( mst_rsp_i       ),
        .mst_rsp_valid_i  ( mst_rsp_valid_i ),
        .mst_rsp_ready_o  ( mst_rsp_ready_o )
    );

endmodule

//--- sim.f
common/atomics_pkg.sv
amo/amo_alu.sv
amo/amo_sequencer.sv
lrsc/reservation_table.sv
lrsc/lrsc_filter.sv
rtl/atomics_adapter.sv
verification/atomics_checker.sv
verification/tb_atomics_adapter.sv

//--- verification/atomics_checker.sv
`timescale 1ns/1ps

module atomics_checker import atomics_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic [8*16-1:0] test_name_i,
    input  amo_req_t        slv_req_i,
    input  logic            slv_req_valid_i,
    input  logic            slv_req_ready_i,
    input  amo_rsp_t        slv_rsp_i,
    input  logic            slv_rsp_valid_i,
    input  logic            slv_rsp_ready_i,
    output int unsigned     rsp_count_o,
    output int unsigned     error_count_o
);

    logic [DATA_WIDTH-1:0] shadow_mem [64];
    logic [NUM_IDS-1:0]    res_valid;
    logic [ADDR_WIDTH-1:0] res_addr [NUM_IDS];
    amo_rsp_t              expected_q [$];
    int unsigned           rsp_count = 0;
    int unsigned           error_count = 0;

    assign rsp_count_o   = rsp_count;
    assign error_count_o = error_count;

    function automatic logic [DATA_WIDTH-1:0] amo_result(input amo_op_e op,
            input logic [DATA_WIDTH-1:0] old, input logic [DATA_WIDTH-1:0] operand);
        case (op)
            OP_ADD:  return old + operand;
            OP_AND:  return old & operand;
            OP_OR:   return old | operand;
            OP_XOR:  return old ^ operand;
            OP_MAX:  return ($signed(old) > $signed(operand)) ? old : operand;
            OP_MIN:  return ($signed(old) < $signed(operand)) ? old : operand;
            OP_MAXU: return (old > operand) ? old : operand;
            OP_MINU: return (old < operand) ? old : operand;
            default: return operand;
        endcase
    endfunction

    // Every write to memory kills all reservations on that word
    function automatic void write_word(input logic [ADDR_WIDTH-1:0] addr,
            input logic [DATA_WIDTH-1:0] data);
        shadow_mem[addr[7:2]] = data;
        for (int i = 0; i < NUM_IDS; i++) begin
            if (res_addr[i] == addr)
                res_valid[i] = 1'b0;
        end
    endfunction

    function automatic amo_rsp_t predict_response(input amo_req_t req);
        amo_rsp_t              rsp;
        logic [DATA_WIDTH-1:0] old;
        old       = shadow_mem[req.addr[7:2]];
        rsp.id    = req.id;
        rsp.rdata = '0;
        case (req.op)
            OP_LOAD:  rsp.rdata = old;
            OP_STORE: write_word(req.addr, req.wdata);
            OP_LR: begin
                rsp.rdata          = old;
                res_valid[req.id]  = 1'b1;
                res_addr[req.id]   = req.addr;
            end
            OP_SC: begin
                if (res_valid[req.id] && res_addr[req.id] == req.addr)
                    write_word(req.addr, req.wdata);
                else
                    rsp.rdata = 1;
                res_valid[req.id] = 1'b0;
            end
            default: begin
                rsp.rdata = old;
                write_word(req.addr, amo_result(req.op, old, req.wdata));
            end
        endcase
        return rsp;
    endfunction

    // Same fill as the memory model in the testbench
    initial begin
        res_valid = '0;
        for (int i = 0; i < 64; i++)
            shadow_mem[i] = ((32'(i) << 2) * 32'h9e37_79b1) ^ 32'hc3a5_0f1e;
    end

    always @(posedge clk_i) begin
        amo_rsp_t    expected;
        int unsigned errs;
        errs = 0;
        if (!rst_i) begin
            if (slv_req_valid_i && slv_req_ready_i)
                expected_q.push_back(predict_response(slv_req_i));
            if (slv_rsp_valid_i && slv_rsp_ready_i) begin
                if (expected_q.size() == 0) begin
                    $display("Response arrived with no request outstanding in %0s",
                             test_name_i);
                    errs++;
                end else begin
                    expected = expected_q.pop_front();
                    if (slv_rsp_i.rdata !== expected.rdata) begin
                        $display("CHECK FAILED %0s: rdata expected %h actual %h",
                                 test_name_i, expected.rdata, slv_rsp_i.rdata);
                        errs++;
                    end
                    if (slv_rsp_i.id !== expected.id) begin
                        $display("CHECK FAILED %0s: id expected %0d actual %0d",
                                 test_name_i, expected.id, slv_rsp_i.id);
                        errs++;
                    end
                end
                rsp_count <= rsp_count + 1;
            end
            error_count <= error_count + errs;
        end
    end

endmodule

//--- verification/tb_atomics_adapter.sv
`timescale 1ns/1ps

module tb_atomics_adapter import atomics_pkg::*; ();

    localparam int DIRECTED_OPS = 50;
    localparam int RANDOM_OPS   = 300;

    logic            clk_i;
    logic            rst_i;
    amo_req_t        slv_req_i;
    logic            slv_req_valid_i;
    logic            slv_req_ready_o;
    amo_rsp_t        slv_rsp_o;
    logic            slv_rsp_valid_o;
    logic            slv_rsp_ready_i;
    mem_req_t        mst_req_o;
    logic            mst_req_valid_o;
    logic            mst_req_ready_i;
    mem_rsp_t        mst_rsp_i;
    logic            mst_rsp_valid_i;
    logic            mst_rsp_ready_o;

    logic [DATA_WIDTH-1:0] mem [64];
    logic [8*16-1:0] test_name;
    logic [31:0]     stim_rng = 32'h76e3_b577;
    logic [31:0]     mem_rng = 32'h76e3_b577 ^ 32'h0000_ffff;
    logic [31:0]     bp_rng = 32'h76e3_b577 ^ 32'hffff_0000;
    logic            throttle = 1'b0;
    int unsigned     issued = 0;
    int unsigned     issued_before;
    int unsigned     errors_before;
    int unsigned     local_errors = 0;
    int unsigned     rsp_count;
    int unsigned     error_count;

    atomics_adapter UUT (.*);

    atomics_checker i_checker (
        .clk_i           ( clk_i           ),
        .rst_i           ( rst_i           ),
        .test_name_i     ( test_name       ),
        .slv_req_i       ( slv_req_i       ),
        .slv_req_valid_i ( slv_req_valid_i ),
        .slv_req_ready_i ( slv_req_ready_o ),
        .slv_rsp_i       ( slv_rsp_o       ),
        .slv_rsp_valid_i ( slv_rsp_valid_o ),
        .slv_rsp_ready_i ( slv_rsp_ready_i ),
        .rsp_count_o     ( rsp_count       ),
        .error_count_o   ( error_count     )
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // Expects to be called 1 ns after a clock edge and returns at the same offset
    task automatic send_request(input amo_op_e op, input logic [ADDR_WIDTH-1:0] addr,
            input logic [DATA_WIDTH-1:0] wdata, input logic [ID_WIDTH-1:0] id);
        slv_req_i       = '{op: op, addr: addr, wdata: wdata, id: id};
        slv_req_valid_i = 1'b1;
        do
            @(posedge clk_i);
        while (!slv_req_ready_o);
        #1;
        slv_req_valid_i = 1'b0;
        issued++;
    endtask

    task automatic open_test(input logic [8*16-1:0] name);
        test_name     = name;
        issued_before = issued;
        errors_before = error_count;
    endtask

    task automatic close_test();
        while (rsp_count != issued) begin
            @(posedge clk_i);
            #1;
        end
        $display("Test %0s done: %0d requests, %0d errors", test_name,
                 issued - issued_before, error_count - errors_before);
    endtask

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // Memory model answering each request after 0 to 3 idle cycles
    initial begin
        mem_req_t req;
        mst_req_ready_i = 1'b1;
        mst_rsp_valid_i = 1'b0;
        mst_rsp_i       = '0;
        for (int i = 0; i < 64; i++)
            mem[i] = ((32'(i) << 2) * 32'h9e37_79b1) ^ 32'hc3a5_0f1e;
        forever begin
            @(posedge clk_i);
            if (mst_req_valid_o && mst_req_ready_i) begin
                req     = mst_req_o;
                mem_rng = xorshift(mem_rng);
                #1;
                mst_rsp_i.rdata = mem[req.addr[7:2]];
                if (req.we)
                    mem[req.addr[7:2]] = req.wdata;
                repeat (mem_rng % 4) begin
                    @(posedge clk_i);
                    #1;
                end
                mst_rsp_valid_i = 1'b1;
                do
                    @(posedge clk_i);
                while (!mst_rsp_ready_o);
                #1;
                mst_rsp_valid_i = 1'b0;
            end
        end
    end

    initial begin
        slv_rsp_ready_i = 1'b1;
        forever begin
            @(posedge clk_i);
            #1;
            bp_rng          = xorshift(bp_rng);
            slv_rsp_ready_i = !throttle || (bp_rng[1:0] != 2'b00);
        end
    end

    initial begin
        repeat ((DIRECTED_OPS + RANDOM_OPS) * 40) @(posedge clk_i);
        $display("Watchdog expired before all responses came back");
        $display("Something failed");
        $finish;
    end

    initial begin
        int unsigned total_errors;
        rst_i           = 1'b1;
        slv_req_i       = '0;
        slv_req_valid_i = 1'b0;
        test_name       = "reset";
        repeat (3) @(posedge clk_i);
        #1;
        rst_i = 1'b0;

        if (slv_rsp_valid_o !== 1'b0 || mst_req_valid_o !== 1'b0 || slv_req_ready_o !== 1'b1) begin
            $display("CHECK FAILED reset_state: expected 001 actual %b%b%b",
                     slv_rsp_valid_o, mst_req_valid_o, slv_req_ready_o);
            local_errors++;
        end
        $display("Test reset_state done: %0d errors", local_errors);

        open_test("loads_stores");
        for (int k = 0; k < 4; k++)
            send_request(OP_STORE, 32'(4 * k), 32'hcafe_0000 + 32'(k), 2'(k));
        for (int k = 0; k < 5; k++)
            send_request(OP_LOAD, 32'(4 * k), '0, 2'(k));
        close_test();

        // Negative word against a small positive operand splits signed from unsigned
        open_test("amo_opcodes");
        for (int k = 0; k < 9; k++) begin
            send_request(OP_STORE, 32'h20 + 32'(4 * k), 32'h8000_0010, 2'd0);
            send_request(amo_op_e'(4'(int'(OP_SWAP) + k)), 32'h20 + 32'(4 * k),
                         32'h0000_0020, 2'(k));
            send_request(OP_LOAD, 32'h20 + 32'(4 * k), '0, 2'd1);
        end
        close_test();

        open_test("lr_sc");
        send_request(OP_LR, 32'h40, '0, 2'd0);
        send_request(OP_SC, 32'h40, 32'h1111_0000, 2'd0);
        send_request(OP_LOAD, 32'h40, '0, 2'd0);
        send_request(OP_SC, 32'h44, 32'h2222_0000, 2'd1);
        send_request(OP_LOAD, 32'h44, '0, 2'd1);
        send_request(OP_LR, 32'h40, '0, 2'd0);
        send_request(OP_STORE, 32'h40, 32'h3333_0000, 2'd2);
        send_request(OP_SC, 32'h40, 32'h4444_0000, 2'd0);
        send_request(OP_LR, 32'h40, '0, 2'd1);
        send_request(OP_ADD, 32'h40, 32'h0000_0001, 2'd3);
        send_request(OP_SC, 32'h40, 32'h5555_0000, 2'd1);
        send_request(OP_LR, 32'h40, '0, 2'd2);
        send_request(OP_STORE, 32'h48, 32'h6666_0000, 2'd3);
        send_request(OP_SC, 32'h40, 32'h7777_0000, 2'd2);
        close_test();

        open_test("random_mix");
        throttle = 1'b1;
        for (int n = 0; n < RANDOM_OPS; n++) begin
            stim_rng = xorshift(stim_rng);
            send_request(amo_op_e'(4'(stim_rng[7:0] % 8'd13)),
                         32'h80 + {27'd0, stim_rng[10:8], 2'b00},
                         xorshift(stim_rng), stim_rng[12:11]);
            if (stim_rng[13]) begin
                @(posedge clk_i);
                #1;
            end
        end
        close_test();
        throttle = 1'b0;

        total_errors = error_count + local_errors;
        $display("Summary: %0d requests, %0d responses checked, %0d errors",
                 issued, rsp_count, total_errors);
        if (total_errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule
